// File: logic/lc3_config.svh
`ifndef LC3_CONFIG_SVH
`define LC3_CONFIG_SVH

// data and address words share one width
`define LC3_WIDTH 16

// general purpose registers R0 to R7
`define LC3_REGS 8

// user programs start here
`define LC3_PC_RESET 16'h3000

`endif

// File: logic/lc3Pkg.sv
package lc3Pkg;

    // source of the next program counter value
    typedef enum logic [1:0] {
        pcIncr     = 2'b00,
        pcFromBus  = 2'b01,
        pcFromAddr = 2'b10
    } pcSelT;

    // offset added to the base in the address adder
    typedef enum logic [1:0] {
        addr2Zero  = 2'b00,
        addr2Off6  = 2'b01,
        addr2Off9  = 2'b10,
        addr2Off11 = 2'b11
    } addr2SelT;

    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluAnd   = 2'b01,
        aluNot   = 2'b10,
        aluPassA = 2'b11
    } aluOpT;

    // exactly one flag is set at any time
    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } ccT;

endpackage

// File: logic/pcUnit.sv
`include "lc3_config.svh"

module pcUnit
    import lc3Pkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  ldPc,
    input  pcSelT                 pcMux,
    input  logic [`LC3_WIDTH-1:0] busIn,
    input  logic [`LC3_WIDTH-1:0] addrIn,
    output logic [`LC3_WIDTH-1:0] pc
);

    logic [`LC3_WIDTH-1:0] pcPlus1;
    logic [`LC3_WIDTH-1:0] pcNext;

    assign pcPlus1 = pc + `LC3_WIDTH'(1); // wraps at the top of memory

    always_comb
    begin
        case (pcMux)
            pcFromBus:  pcNext = busIn;
            pcFromAddr: pcNext = addrIn; // branch, JSR and JMP targets
            default:    pcNext = pcPlus1;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc <= `LC3_PC_RESET;
        end
        else if (ldPc)
        begin
            pc <= pcNext;
        end
    end

endmodule

// File: logic/regFile.sv
`include "lc3_config.svh"

module regFile #(
    localparam int IdxW = $clog2(`LC3_REGS)
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  ldReg,
    input  logic [IdxW-1:0]       dr,
    input  logic [IdxW-1:0]       sr1,
    input  logic [IdxW-1:0]       sr2,
    input  logic [`LC3_WIDTH-1:0] busIn,
    output logic [`LC3_WIDTH-1:0] sr1Out,
    output logic [`LC3_WIDTH-1:0] sr2Out
);

    logic [`LC3_WIDTH-1:0] regs [`LC3_REGS];

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `LC3_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (ldReg)
        begin
            regs[dr] <= busIn;
        end
    end

    // reads see the old value during a write cycle
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

// File: logic/aluUnit.sv
`include "lc3_config.svh"

module aluUnit
    import lc3Pkg::*;
(
    input  aluOpT                 aluK,
    input  logic [`LC3_WIDTH-1:0] a,
    input  logic [`LC3_WIDTH-1:0] b,
    input  logic [5:0]            ir,
    output logic [`LC3_WIDTH-1:0] aluOut
);

    logic [`LC3_WIDTH-1:0] imm5;
    logic [`LC3_WIDTH-1:0] opB;

    assign imm5 = {{(`LC3_WIDTH-5){ir[4]}}, ir[4:0]};

    // ir bit 5 marks the immediate form of ADD and AND
    assign opB = ir[5] ? imm5 : b;

    always_comb
    begin
        case (aluK)
            aluAdd:
            begin
                aluOut = a + opB;
            end
            aluAnd:
            begin
                aluOut = a & opB;
            end
            aluNot:
            begin
                aluOut = ~a;
            end
            default:
            begin
                aluOut = a; // pass lets a register reach the bus unchanged
            end
        endcase
    end

endmodule

// File: logic/addrAdder.sv
`include "lc3_config.svh"

module addrAdder
    import lc3Pkg::*;
(
    input  logic                  addr1Mux,
    input  addr2SelT              addr2Mux,
    input  logic [`LC3_WIDTH-1:0] pc,
    input  logic [`LC3_WIDTH-1:0] base,
    input  logic [10:0]           ir,
    output logic [`LC3_WIDTH-1:0] addrOut
);

    logic [`LC3_WIDTH-1:0] addr1;
    logic [`LC3_WIDTH-1:0] addr2;
    logic [`LC3_WIDTH-1:0] off6;
    logic [`LC3_WIDTH-1:0] off9;
    logic [`LC3_WIDTH-1:0] off11;

    assign off6  = {{(`LC3_WIDTH-6){ir[5]}}, ir[5:0]};   // LDR and STR
    assign off9  = {{(`LC3_WIDTH-9){ir[8]}}, ir[8:0]};   // BR, LD, ST, LEA
    assign off11 = {{(`LC3_WIDTH-11){ir[10]}}, ir[10:0]}; // JSR

    // base register form is used by LDR, STR and JMP
    assign addr1 = addr1Mux ? base : pc;

    always_comb
    begin
        case (addr2Mux)
            addr2Off6:  addr2 = off6;
            addr2Off9:  addr2 = off9;
            addr2Off11: addr2 = off11;
            default:    addr2 = '0;
        endcase
    end

    assign addrOut = addr1 + addr2;

endmodule

// File: logic/memBridge.sv
`include "lc3_config.svh"

module memBridge (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  ldMar,
    input  logic                  ldMdr,
    input  logic                  mioEn,
    input  logic [`LC3_WIDTH-1:0] busIn,
    input  logic [`LC3_WIDTH-1:0] memData,
    output logic [`LC3_WIDTH-1:0] mar,
    output logic [`LC3_WIDTH-1:0] mdr
);

    logic [`LC3_WIDTH-1:0] mdrIn;

    // memory read data only when the memory is enabled, else a store value from the bus
    assign mdrIn = mioEn ? memData : busIn;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            mar <= '0;
            mdr <= '0;
        end
        else
        begin
            if (ldMar)
            begin
                mar <= busIn;
            end
            if (ldMdr)
            begin
                mdr <= mdrIn;
            end
        end
    end

endmodule

// File: logic/lc3Datapath.sv
`include "lc3_config.svh"

module lc3Datapath
    import lc3Pkg::*;
#(
    localparam int IdxW = $clog2(`LC3_REGS)
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  ldMar,
    input  logic                  ldMdr,
    input  logic                  ldIr,
    input  logic                  ldBen,
    input  logic                  ldCc,
    input  logic                  ldReg,
    input  logic                  ldPc,
    input  logic                  gatePc,
    input  logic                  gateMdr,
    input  logic                  gateAlu,
    input  logic                  gateMarMux,
    input  pcSelT                 pcMux,
    input  addr2SelT              addr2Mux,
    input  aluOpT                 aluK,
    input  logic                  drMux,
    input  logic                  sr1Mux,
    input  logic                  addr1Mux,
    input  logic                  mioEn,
    input  logic [`LC3_WIDTH-1:0] memData,
    output logic [`LC3_WIDTH-1:0] mar,
    output logic [`LC3_WIDTH-1:0] mdr,
    output logic [`LC3_WIDTH-1:0] pc,
    output logic [`LC3_WIDTH-1:0] ir,
    output ccT                    nzp,
    output logic                  ben
);

    logic [`LC3_WIDTH-1:0] bus;
    logic [`LC3_WIDTH-1:0] aluOut;
    logic [`LC3_WIDTH-1:0] addrOut;
    logic [`LC3_WIDTH-1:0] sr1Out;
    logic [`LC3_WIDTH-1:0] sr2Out;
    logic [IdxW-1:0]       dr;
    logic [IdxW-1:0]       sr1;
    logic [IdxW-1:0]       sr2;
    ccT                    ccNext;

    // a single driver wins even if the control word raises several gates
    always_comb
    begin
        if (gateMdr)
            bus = mdr;
        else if (gateAlu)
            bus = aluOut;
        else if (gatePc)
            bus = pc;
        else if (gateMarMux)
            bus = addrOut; // no trap vector path, the adder is the only marMux source
        else
            bus = '0;
    end

    assign dr  = drMux ? {IdxW{1'b1}} : ir[11:9]; // JSR links through R7
    assign sr1 = sr1Mux ? ir[11:9] : ir[8:6];     // ST and STR take their source from 11:9
    assign sr2 = ir[2:0];

    assign ccNext.n = bus[`LC3_WIDTH-1];
    assign ccNext.z = (bus == '0);
    assign ccNext.p = !bus[`LC3_WIDTH-1] && (bus != '0);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            ir  <= '0;
            nzp <= '{n: 1'b0, z: 1'b1, p: 1'b0};
            ben <= 1'b0;
        end
        else
        begin
            if (ldIr)
                ir <= bus;
            if (ldCc)
                nzp <= ccNext;
            if (ldBen)
                ben <= |(ir[11:9] & nzp); // branch mask against the flags held now
        end
    end

    pcUnit pcUnit_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .ldPc   (ldPc),
        .pcMux  (pcMux),
        .busIn  (bus),
        .addrIn (addrOut),
        .pc     (pc)
    );

    regFile regFile_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .ldReg  (ldReg),
        .dr     (dr),
        .sr1    (sr1),
        .sr2    (sr2),
        .busIn  (bus),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out)
    );

    aluUnit aluUnit_i (
        .aluK   (aluK),
        .a      (sr1Out),
        .b      (sr2Out),
        .ir     (ir[5:0]),
        .aluOut (aluOut)
    );

    addrAdder addrAdder_i (
        .addr1Mux (addr1Mux),
        .addr2Mux (addr2Mux),
        .pc       (pc),
        .base     (sr1Out),
        .ir       (ir[10:0]),
        .addrOut  (addrOut)
    );

    memBridge memBridge_i (
        .Clk     (Clk),
        .rstN    (rstN),
        .ldMar   (ldMar),
        .ldMdr   (ldMdr),
        .mioEn   (mioEn),
        .busIn   (bus),
        .memData (memData),
        .mar     (mar),
        .mdr     (mdr)
    );

endmodule

// File: bench/lc3Datapath_sva.sv
`include "lc3_config.svh"

module lc3DatapathSva (
    input logic                  Clk,
    input logic                  rstN,
    input logic                  gatePc,
    input logic                  gateMdr,
    input logic                  gateAlu,
    input logic                  gateMarMux,
    input logic                  ldPc,
    input logic [`LC3_WIDTH-1:0] pc,
    input logic [2:0]            nzp
);
    timeunit 1ns;
    timeprecision 1ps;

    // a gate cycle is followed by at most one raised gate
    assert property (@(posedge Clk) disable iff (!rstN)
        (gatePc || gateMdr || gateAlu || gateMarMux)
            |=> $onehot0({gatePc, gateMdr, gateAlu, gateMarMux}))
        else $error("several bus gates are high in the cycle after a gate cycle");

    assert property (@(posedge Clk) disable iff (!rstN) !ldPc |=> $stable(pc))
        else $error("PC changed without ldPc");

    assert property (@(posedge Clk) disable iff (!rstN) $onehot(nzp))
        else $error("condition codes are not one-hot");

endmodule

bind lc3Datapath lc3DatapathSva lc3DatapathSva_i (
    .Clk(Clk), .rstN(rstN), .gatePc(gatePc), .gateMdr(gateMdr), .gateAlu(gateAlu),
    .gateMarMux(gateMarMux), .ldPc(ldPc), .pc(pc), .nzp(nzp)
);

// File: bench/lc3DatapathTb.sv
`include "lc3_config.svh"

module lc3DatapathTb
    import lc3Pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // control word bits, load enables first and mioEn last
    localparam logic [20:0] cLdMar = 21'h100000;
    localparam logic [20:0] cLdMdr = 21'h080000;
    localparam logic [20:0] cLdIr = 21'h040000;
    localparam logic [20:0] cLdBen = 21'h020000;
    localparam logic [20:0] cLdCc = 21'h010000;
    localparam logic [20:0] cLdReg = 21'h008000;
    localparam logic [20:0] cLdPc = 21'h004000;
    localparam logic [20:0] cGatePc = 21'h002000;
    localparam logic [20:0] cGateMdr = 21'h001000;
    localparam logic [20:0] cGateAlu = 21'h000800;
    localparam logic [20:0] cGateMar = 21'h000400;
    localparam logic [20:0] cPcAddr = 21'(pcFromAddr) << 8;
    localparam logic [20:0] cOff6 = 21'(addr2Off6) << 6;
    localparam logic [20:0] cOff9 = 21'(addr2Off9) << 6;
    localparam logic [20:0] cAnd = 21'(aluAnd) << 4;
    localparam logic [20:0] cNot = 21'(aluNot) << 4;
    localparam logic [20:0] cPass = 21'(aluPassA) << 4;
    localparam logic [20:0] cSr1Mux = 21'h4;
    localparam logic [20:0] cAddr1Mux = 21'h2;
    localparam logic [20:0] cMioEn = 21'h1;

    typedef struct {
        logic [20:0]           ctrl;
        logic [`LC3_WIDTH-1:0] pc, mar, mdr, ir;
        logic [2:0]            nzp;
        logic                  ben;
    } stepT;

    logic Clk = 1'b0;
    logic rstN = 1'b0;
    logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc;
    logic gatePc, gateMdr, gateAlu, gateMarMux, drMux, sr1Mux, addr1Mux, mioEn;
    pcSelT pcMux;
    addr2SelT addr2Mux;
    aluOpT aluK;
    logic [`LC3_WIDTH-1:0] memData, mar, mdr, pc, ir;
    ccT nzp;
    logic ben;

    logic [`LC3_WIDTH-1:0] mem [logic [`LC3_WIDTH-1:0]];
    stepT steps[$];
    logic [`LC3_WIDTH-1:0] trkPc = `LC3_PC_RESET;
    logic [`LC3_WIDTH-1:0] trkMar = '0;
    logic [`LC3_WIDTH-1:0] trkMdr = '0;
    logic [`LC3_WIDTH-1:0] trkIr = '0;
    logic [2:0] trkNzp = 3'b010;
    logic trkBen = 1'b0;
    int errors = 0;
    int checks = 0;
    int waitCnt = 0;

    always #20 Clk = ~Clk;

    function automatic logic [`LC3_WIDTH-1:0] readMem(input logic [`LC3_WIDTH-1:0] addr);
        // words never written read back as a pattern of their own address
        return mem.exists(addr) ? mem[addr] : addr ^ 16'h5a5a;
    endfunction

    assign memData = readMem(mar);

    lc3Datapath lc3Datapath_i (.*);

    task automatic addStep(input logic [20:0] c, input logic [15:0] p, m, d, i,
                           input logic [2:0] cc, input logic b);
        stepT s;
        s = '{c, p, m, d, i, cc, b};
        steps.push_back(s);
        trkPc = p;
        trkMar = m;
        trkMdr = d;
        trkIr = i;
        trkNzp = cc;
        trkBen = b;
    endtask

    // three cycles of an instruction fetch from the current PC
    task automatic addFetch(input logic [15:0] word);
        mem[trkPc] = word;
        addStep(cGatePc | cLdMar | cLdPc, trkPc + 16'd1, trkPc, trkMdr, trkIr, trkNzp, trkBen);
        addStep(cMioEn | cLdMdr, trkPc, trkMar, word, trkIr, trkNzp, trkBen);
        addStep(cGateMdr | cLdIr, trkPc, trkMar, word, word, trkNzp, trkBen);
    endtask

    task automatic applyCtrl(input logic [20:0] c);
        ldMar <= c[20];
        ldMdr <= c[19];
        ldIr <= c[18];
        ldBen <= c[17];
        ldCc <= c[16];
        ldReg <= c[15];
        ldPc <= c[14];
        gatePc <= c[13];
        gateMdr <= c[12];
        gateAlu <= c[11];
        gateMarMux <= c[10];
        pcMux <= pcSelT'(c[9:8]);
        addr2Mux <= addr2SelT'(c[7:6]);
        aluK <= aluOpT'(c[5:4]);
        drMux <= c[3];
        sr1Mux <= c[2];
        addr1Mux <= c[1];
        mioEn <= c[0];
    endtask

    task automatic checkValue(input string name, input int step, input logic [15:0] got, exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH step %0d %s got %h expected %h", step, name, got, exp);
        end
    endtask

    initial
    begin
        applyCtrl('0);
        addStep('0, 16'h3000, 16'h0000, 16'h0000, 16'h0000, 3'b010, 1'b0); // reset values
        addFetch(16'h1234);                                                  // data for R1
        addStep(cGateMdr | cLdReg | cLdCc, 16'h3001, 16'h3000, 16'h1234, 16'h1234, 3'b001, 0);
        addFetch(16'h8a5c);                                                  // data for R5
        addStep(cGateMdr | cLdReg | cLdCc, 16'h3002, 16'h3001, 16'h8a5c, 16'h8a5c, 3'b100, 0);
        addStep(cLdBen, 16'h3002, 16'h3001, 16'h8a5c, 16'h8a5c, 3'b100, 1);
        addFetch(16'h1445);                                                  // ADD R2, R1, R5
        addStep(cGateAlu | cLdReg | cLdCc, 16'h3003, 16'h3002, 16'h1445, 16'h1445, 3'b100, 1);
        addStep(cGateAlu | cPass | cSr1Mux | cLdMar | cLdBen,
                16'h3003, 16'h9c90, 16'h1445, 16'h1445, 3'b100, 0);
        addFetch(16'h167d);                                                  // ADD R3, R1, #-3
        addStep(cGateAlu | cLdReg | cLdCc, 16'h3004, 16'h3003, 16'h167d, 16'h167d, 3'b001, 0);
        addStep(cGateAlu | cPass | cSr1Mux | cLdMar | cLdBen,
                16'h3004, 16'h1231, 16'h167d, 16'h167d, 3'b001, 1);
        addFetch(16'h5941);                                                  // AND R4, R5, R1
        addStep(cGateAlu | cAnd | cLdReg | cLdCc,
                16'h3005, 16'h3004, 16'h5941, 16'h5941, 3'b001, 1);
        addStep(cGateAlu | cPass | cSr1Mux | cLdMar | cLdBen,
                16'h3005, 16'h0214, 16'h5941, 16'h5941, 3'b001, 0);
        addFetch(16'h5c60);                                                  // AND R6, R1, #0
        addStep(cGateAlu | cAnd | cLdReg | cLdCc,
                16'h3006, 16'h3005, 16'h5c60, 16'h5c60, 3'b010, 0);
        addStep(cGateAlu | cPass | cSr1Mux | cLdMar | cLdBen,
                16'h3006, 16'h0000, 16'h5c60, 16'h5c60, 3'b010, 1);
        addFetch(16'h9e7f);                                                  // NOT R7, R1
        addStep(cGateAlu | cNot | cLdReg | cLdCc,
                16'h3007, 16'h3006, 16'h9e7f, 16'h9e7f, 3'b100, 1);
        addStep(cGateAlu | cPass | cSr1Mux | cLdMar | cLdBen,
                16'h3007, 16'hedcb, 16'h9e7f, 16'h9e7f, 3'b100, 1);
        addFetch(16'h21fe);                                                  // PC plus offset9 of -2
        addStep(cGateMar | cOff9 | cLdMar, 16'h3008, 16'h3006, 16'h21fe, 16'h21fe, 3'b100, 1);
        addStep(cMioEn | cLdMdr, 16'h3008, 16'h3006, 16'h9e7f, 16'h21fe, 3'b100, 1);
        addFetch(16'h6085);                                                  // R2 plus offset6 of 5
        addStep(cGateMar | cAddr1Mux | cOff6 | cLdMar,
                16'h3009, 16'h9c95, 16'h6085, 16'h6085, 3'b100, 1);
        addStep(cGateAlu | cPass | cLdMdr, 16'h3009, 16'h9c95, 16'h9c90, 16'h6085, 3'b100, 1);
        addFetch(16'h0e10);                                                  // BRnzp to PC plus 16
        addStep(cLdBen | cLdPc | cPcAddr | cOff9,
                16'h301a, 16'h3009, 16'h0e10, 16'h0e10, 3'b100, 1);
        addStep(cGatePc | cGateMdr | cGateAlu | cGateMar | cNot | cLdMar,
                16'h301a, 16'h0e10, 16'h0e10, 16'h0e10, 3'b100, 1);
        addStep(cGatePc | cGateAlu | cGateMar | cNot | cLdMar,
                16'h301a, 16'hffff, 16'h0e10, 16'h0e10, 3'b100, 1);
        addStep(cGatePc | cGateMar | cLdMar, 16'h301a, 16'h301a, 16'h0e10, 16'h0e10, 3'b100, 1);
        addStep(cGateMar | cOff9 | cLdMar, 16'h301a, 16'h302a, 16'h0e10, 16'h0e10, 3'b100, 1);
        addStep(cLdMar, 16'h301a, 16'h0000, 16'h0e10, 16'h0e10, 3'b100, 1);

        repeat (10) @(posedge Clk);
        rstN <= 1'b1;
        while (!rstN && waitCnt < 50)
        begin
            @(posedge Clk);
            waitCnt++;
        end
        if (!rstN)
        begin
            $display("Timeout waiting for reset release");
            $display("Errors found");
        end
        else
        begin
            foreach (steps[i])
            begin
                @(posedge Clk);
                applyCtrl(steps[i].ctrl);
                @(posedge Clk);
                applyCtrl('0);
                @(negedge Clk); // the registers have settled after the loading edge
                checkValue("pc", i, pc, steps[i].pc);
                checkValue("mar", i, mar, steps[i].mar);
                checkValue("mdr", i, mdr, steps[i].mdr);
                checkValue("ir", i, ir, steps[i].ir);
                checkValue("nzp", i, {13'b0, nzp}, {13'b0, steps[i].nzp});
                checkValue("ben", i, {15'b0, ben}, {15'b0, steps[i].ben});
            end
            $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
            if (errors == 0)
                $display("No errors");
            else
                $display("Errors found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/lc3Pkg.sv
logic/pcUnit.sv
logic/regFile.sv
logic/aluUnit.sv
logic/addrAdder.sv
logic/memBridge.sv
logic/lc3Datapath.sv
bench/lc3Datapath_sva.sv
bench/lc3DatapathTb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Mdir obj_dir
TOP        = lc3DatapathTb
FILELIST   = build.f
PASS_TEXT  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf obj_dir
